//--- alloc_defines.svh
`ifndef ALLOC_DEFINES_SVH
`define ALLOC_DEFINES_SVH

// Data path width
`define ALLOC_DATA_W 32

// Register index width, shared by general and system ids
`define ALLOC_REG_AW 5

// General register count
`define ALLOC_NUM_GREGS 32

// PSR bits cleared on interrupt entry (bits 6, 5 and 2)
`define ALLOC_PSR_IRQ_MASK 32'h0000_0064

`endif

//--- alloc_reg_pkg.sv
`default_nettype none

`include "alloc_defines.svh"

package alloc_reg_pkg;

	// General register index
	typedef logic [`ALLOC_REG_AW-1:0] greg_idx_t;

	// System register ids, other codes name no register
	typedef enum logic [`ALLOC_REG_AW-1:0] {
		SR_PSR  = 5'd0,
		SR_SPR  = 5'd1,
		SR_IDTR = 5'd2,
		SR_PPSR = 5'd3
	} sysreg_id_t;

endpackage

`default_nettype wire

//--- alloc_op_pkg.sv
`default_nettype none

package alloc_op_pkg;

	// Opcodes carried to execute
	typedef enum logic [4:0] {
		CMD_NOP   = 5'd0,
		CMD_ADD   = 5'd1,
		CMD_SUB   = 5'd2,
		CMD_AND   = 5'd3,
		CMD_OR    = 5'd4,
		CMD_SHL   = 5'd5,
		CMD_LD    = 5'd6,
		CMD_ST    = 5'd7,
		CMD_BR    = 5'd8,
		CMD_SRMOV = 5'd9
	} alloc_cmd_t;

endpackage

`default_nettype wire

//--- gen_reg_file.sv
`default_nettype none

`include "alloc_defines.svh"

module gen_reg_file
	import alloc_reg_pkg::*;
(
	input  wire                      iCLOCK,
	input  wire                      wr_en,
	input  greg_idx_t                wr_addr,
	input  wire [`ALLOC_DATA_W-1:0]  wr_data,
	input  greg_idx_t                rd0_addr,
	output logic [`ALLOC_DATA_W-1:0] rd0_data,
	input  greg_idx_t                rd1_addr,
	output logic [`ALLOC_DATA_W-1:0] rd1_data
);

	logic [`ALLOC_DATA_W-1:0] regs [`ALLOC_NUM_GREGS];

	// Single write port
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Asynchronous reads, old data until the write edge
	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];

endmodule

`default_nettype wire

//--- sys_reg_bank.sv
`default_nettype none

`include "alloc_defines.svh"

module sys_reg_bank
	import alloc_reg_pkg::*;
(
	input  wire                      iCLOCK,
	input  wire                      inRESET,
	input  wire                      irq_enter,
	input  wire                      irq_return,
	input  wire                      wr_en,
	input  sysreg_id_t               wr_id,
	input  wire [`ALLOC_DATA_W-1:0]  wr_data,
	input  sysreg_id_t               rd0_id,
	output logic [`ALLOC_DATA_W-1:0] rd0_data,
	input  sysreg_id_t               rd1_id,
	output logic [`ALLOC_DATA_W-1:0] rd1_data,
	output logic [`ALLOC_DATA_W-1:0] psr,
	output logic [`ALLOC_DATA_W-1:0] ppsr,
	output logic [`ALLOC_DATA_W-1:0] spr,
	output logic [`ALLOC_DATA_W-1:0] idtr
);

	function automatic logic [`ALLOC_DATA_W-1:0] sr_read(input sysreg_id_t id);
		logic [`ALLOC_DATA_W-1:0] val;
		case (id)
			SR_PSR:  val = psr;
			SR_SPR:  val = spr;
			SR_IDTR: val = idtr;
			SR_PPSR: val = ppsr;
			default: val = '0;
		endcase
		return val;
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr  <= '0;
			ppsr <= '0;
			spr  <= '0;
			idtr <= '0;
		end else begin
			// Entry masks interrupts, return restores saved status
			if (irq_enter) begin
				psr <= psr & ~`ALLOC_PSR_IRQ_MASK;
			end else if (irq_return) begin
				psr <= ppsr;
			end else if (wr_en && wr_id == SR_PSR) begin
				psr <= wr_data;
			end
			if (irq_enter) begin
				ppsr <= psr;
			end else if (wr_en && wr_id == SR_PPSR) begin
				ppsr <= wr_data;
			end
			if (wr_en && wr_id == SR_SPR) begin
				spr <= wr_data;
			end
			if (wr_en && wr_id == SR_IDTR) begin
				idtr <= wr_data;
			end
		end
	end

	always_comb begin
		rd0_data = sr_read(rd0_id);
	end

	always_comb begin
		rd1_data = sr_read(rd1_id);
	end

	// Entry and return are exclusive events
	a_irq_exclusive: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(irq_enter && irq_return));

endmodule

`default_nettype wire

//--- operand_fetch.sv
`default_nettype none

`include "alloc_defines.svh"

module operand_fetch
	import alloc_reg_pkg::*;
(
	input  wire                      wb_valid,
	input  greg_idx_t                wb_dest,
	input  wire                      wb_dest_sys,
	input  wire [`ALLOC_DATA_W-1:0]  wb_data,
	input  greg_idx_t                src0,
	input  wire                      src0_sys,
	input  greg_idx_t                src1,
	input  wire                      src1_sys,
	input  wire                      src1_imm,
	input  wire [`ALLOC_DATA_W-1:0]  imm,
	input  wire [`ALLOC_DATA_W-1:0]  gr_rd0_data,
	input  wire [`ALLOC_DATA_W-1:0]  gr_rd1_data,
	input  wire [`ALLOC_DATA_W-1:0]  sr_rd0_data,
	input  wire [`ALLOC_DATA_W-1:0]  sr_rd1_data,
	output logic                     gr_wr_en,
	output logic                     sr_wr_en,
	output logic [`ALLOC_DATA_W-1:0] src0_val,
	output logic [`ALLOC_DATA_W-1:0] src1_val
);

	logic src0_hit;
	logic src1_hit;

	// Writeback steering
	assign gr_wr_en = wb_valid && !wb_dest_sys;
	assign sr_wr_en = wb_valid && wb_dest_sys;

	// Bypass needs same index and same register space
	assign src0_hit = wb_valid && (src0 == wb_dest) && (src0_sys == wb_dest_sys);
	assign src1_hit = wb_valid && (src1 == wb_dest) && (src1_sys == wb_dest_sys);

	always_comb begin
		if (src0_hit) begin
			src0_val = wb_data;
		end else if (src0_sys) begin
			src0_val = sr_rd0_data;
		end else begin
			src0_val = gr_rd0_data;
		end
	end

	// Immediate wins over everything
	always_comb begin
		if (src1_imm) begin
			src1_val = imm;
		end else if (src1_hit) begin
			src1_val = wb_data;
		end else if (src1_sys) begin
			src1_val = sr_rd1_data;
		end else begin
			src1_val = gr_rd1_data;
		end
	end

endmodule

`default_nettype wire

//--- alloc_pipe_reg.sv
`default_nettype none

`include "alloc_defines.svh"

module alloc_pipe_reg
	import alloc_reg_pkg::*, alloc_op_pkg::*;
(
	input  wire                      iCLOCK,
	input  wire                      inRESET,
	input  wire                      flush,
	input  wire                      in_valid,
	output logic                     in_ready,
	input  alloc_cmd_t               in_cmd,
	input  wire [`ALLOC_DATA_W-1:0]  in_pc,
	input  greg_idx_t                in_dest,
	input  wire                      in_dest_sys,
	input  wire                      in_writeback,
	input  wire [`ALLOC_DATA_W-1:0]  src0_val,
	input  wire [`ALLOC_DATA_W-1:0]  src1_val,
	output logic                     out_valid,
	input  wire                      out_ready,
	output alloc_cmd_t               out_cmd,
	output logic [`ALLOC_DATA_W-1:0] out_pc,
	output greg_idx_t                out_dest,
	output logic                     out_dest_sys,
	output logic                     out_writeback,
	output logic [`ALLOC_DATA_W-1:0] out_src0,
	output logic [`ALLOC_DATA_W-1:0] out_src1
);

	// No acceptance during a flush cycle
	assign in_ready = (!out_valid || out_ready) && !flush;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (in_valid && in_ready) begin
			out_cmd       <= in_cmd;
			out_pc        <= in_pc;
			out_dest      <= in_dest;
			out_dest_sys  <= in_dest_sys;
			out_writeback <= in_writeback;
			out_src0      <= src0_val;
			out_src1      <= src1_val;
		end
	end

	// Held item stays put until taken
	a_hold_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_cmd)
		&& $stable(out_pc) && $stable(out_dest) && $stable(out_dest_sys)
		&& $stable(out_writeback) && $stable(out_src0) && $stable(out_src1)));

endmodule

`default_nettype wire

//--- alloc_stage.sv
`default_nettype none

`include "alloc_defines.svh"

module alloc_stage
	import alloc_reg_pkg::*, alloc_op_pkg::*;
(
	input  wire                      iCLOCK,
	input  wire                      inRESET,
	input  wire                      in_valid,
	output logic                     in_ready,
	input  alloc_cmd_t               in_cmd,
	input  wire [`ALLOC_DATA_W-1:0]  in_pc,
	input  greg_idx_t                in_dest,
	input  wire                      in_dest_sys,
	input  wire                      in_writeback,
	input  greg_idx_t                in_src0,
	input  wire                      in_src0_sys,
	input  greg_idx_t                in_src1,
	input  wire                      in_src1_sys,
	input  wire                      in_src1_imm,
	input  wire [`ALLOC_DATA_W-1:0]  in_imm,
	output logic                     out_valid,
	input  wire                      out_ready,
	output alloc_cmd_t               out_cmd,
	output logic [`ALLOC_DATA_W-1:0] out_pc,
	output greg_idx_t                out_dest,
	output logic                     out_dest_sys,
	output logic                     out_writeback,
	output logic [`ALLOC_DATA_W-1:0] out_src0,
	output logic [`ALLOC_DATA_W-1:0] out_src1,
	input  wire                      wb_valid,
	input  greg_idx_t                wb_dest,
	input  wire                      wb_dest_sys,
	input  wire [`ALLOC_DATA_W-1:0]  wb_data,
	input  wire                      flush,
	input  wire                      irq_enter,
	input  wire                      irq_return,
	output logic [`ALLOC_DATA_W-1:0] psr,
	output logic [`ALLOC_DATA_W-1:0] ppsr,
	output logic [`ALLOC_DATA_W-1:0] spr,
	output logic [`ALLOC_DATA_W-1:0] idtr
);

	logic                     gr_wr_en;
	logic                     sr_wr_en;
	logic [`ALLOC_DATA_W-1:0] gr_rd0_data;
	logic [`ALLOC_DATA_W-1:0] gr_rd1_data;
	logic [`ALLOC_DATA_W-1:0] sr_rd0_data;
	logic [`ALLOC_DATA_W-1:0] sr_rd1_data;
	logic [`ALLOC_DATA_W-1:0] src0_val;
	logic [`ALLOC_DATA_W-1:0] src1_val;

	gen_reg_file u_grf (
		.iCLOCK(iCLOCK), .wr_en(gr_wr_en), .wr_addr(wb_dest), .wr_data(wb_data),
		.rd0_addr(in_src0), .rd0_data(gr_rd0_data),
		.rd1_addr(in_src1), .rd1_data(gr_rd1_data)
	);

	// Source fields double as system register ids
	sys_reg_bank u_srb (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.irq_enter(irq_enter), .irq_return(irq_return),
		.wr_en(sr_wr_en), .wr_id(sysreg_id_t'(wb_dest)), .wr_data(wb_data),
		.rd0_id(sysreg_id_t'(in_src0)), .rd0_data(sr_rd0_data),
		.rd1_id(sysreg_id_t'(in_src1)), .rd1_data(sr_rd1_data),
		.psr(psr), .ppsr(ppsr), .spr(spr), .idtr(idtr)
	);

	operand_fetch u_opf (
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_dest_sys(wb_dest_sys),
		.wb_data(wb_data),
		.src0(in_src0), .src0_sys(in_src0_sys),
		.src1(in_src1), .src1_sys(in_src1_sys),
		.src1_imm(in_src1_imm), .imm(in_imm),
		.gr_rd0_data(gr_rd0_data), .gr_rd1_data(gr_rd1_data),
		.sr_rd0_data(sr_rd0_data), .sr_rd1_data(sr_rd1_data),
		.gr_wr_en(gr_wr_en), .sr_wr_en(sr_wr_en),
		.src0_val(src0_val), .src1_val(src1_val)
	);

	alloc_pipe_reg u_pipe (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(flush),
		.in_valid(in_valid), .in_ready(in_ready), .in_cmd(in_cmd), .in_pc(in_pc),
		.in_dest(in_dest), .in_dest_sys(in_dest_sys), .in_writeback(in_writeback),
		.src0_val(src0_val), .src1_val(src1_val),
		.out_valid(out_valid), .out_ready(out_ready), .out_cmd(out_cmd),
		.out_pc(out_pc), .out_dest(out_dest), .out_dest_sys(out_dest_sys),
		.out_writeback(out_writeback), .out_src0(out_src0), .out_src1(out_src1)
	);

endmodule

`default_nettype wire

//--- tb_alloc_stage.sv
`default_nettype none

`include "alloc_defines.svh"

module tb_alloc_stage
	import alloc_reg_pkg::*, alloc_op_pkg::*;
();

	typedef logic [`ALLOC_DATA_W-1:0] word_t;
	typedef logic [107:0] item_t;

	localparam int N_TESTS = 6;
	localparam int TEST_LEN = 200;

	logic       iCLOCK = 1'b0;
	logic       inRESET, flush, irq_enter, irq_return, wb_valid, wb_dest_sys;
	logic       in_valid, in_ready, in_dest_sys, in_writeback, in_src0_sys, in_src1_sys;
	logic       in_src1_imm, out_valid, out_ready, out_dest_sys, out_writeback;
	alloc_cmd_t in_cmd, out_cmd;
	greg_idx_t  in_dest, in_src0, in_src1, out_dest, wb_dest;
	word_t      in_pc, in_imm, out_pc, out_src0, out_src1, wb_data, psr, ppsr, spr, idtr;

	// Reference model and scoreboard
	word_t      m_greg [`ALLOC_NUM_GREGS];
	word_t      m_psr = '0, m_ppsr = '0, m_spr = '0, m_idtr = '0;
	item_t      exp_q[$];
	item_t      held_item;
	logic       held = 1'b0;
	int         errors = 0, checked = 0, cycles = 0;
	string      names [N_TESTS] = '{"greg_fill", "bypass", "imm_sysreg", "backpressure",
		"irq", "flush"};

	alloc_stage UUT (.*);

	always #2 iCLOCK = ~iCLOCK;

	task automatic report_error(input string msg);
		$display("ERROR @%0t: %s", $time, msg);
		errors++;
	endtask

	// Operand value by the bypass and selection rules
	function automatic word_t expect_src(input greg_idx_t idx, input logic sys);
		if (wb_valid && idx == wb_dest && sys == wb_dest_sys)
			return wb_data;
		if (!sys)
			return m_greg[idx];
		case (idx)
			5'd0: return m_psr;
			5'd1: return m_spr;
			5'd2: return m_idtr;
			5'd3: return m_ppsr;
			default: return '0;
		endcase
	endfunction

	// Compare at the falling edge, then step the model to the next rising edge
	always @(negedge iCLOCK) begin
		item_t got;
		word_t old_psr;
		word_t old_ppsr;
		if (inRESET) begin
			got = {out_cmd, out_pc, out_dest, out_dest_sys, out_writeback, out_src0, out_src1};
			if (out_valid !== (exp_q.size() != 0))
				report_error($sformatf("out_valid is %b", out_valid));
			if (in_ready !== ((exp_q.size() == 0 || out_ready) && !flush))
				report_error($sformatf("in_ready is %b", in_ready));
			if ({psr, ppsr, spr, idtr} !== {m_psr, m_ppsr, m_spr, m_idtr})
				report_error($sformatf("status %h, expected %h", {psr, ppsr, spr, idtr},
					{m_psr, m_ppsr, m_spr, m_idtr}));
			if (held && got !== held_item)
				report_error("held item changed before it was taken");
			if (out_valid && out_ready && exp_q.size() != 0) begin
				if (got !== exp_q[0])
					report_error($sformatf("item %h, expected %h", got, exp_q[0]));
				void'(exp_q.pop_front());
				checked++;
			end else if (flush && exp_q.size() != 0) begin
				// Held item dropped
				void'(exp_q.pop_front());
			end
			held = out_valid && !out_ready && !flush;
			held_item = got;
			if (in_valid && in_ready)
				exp_q.push_back({in_cmd, in_pc, in_dest, in_dest_sys, in_writeback,
					expect_src(in_src0, in_src0_sys),
					(in_src1_imm ? in_imm : expect_src(in_src1, in_src1_sys))});
			old_psr = m_psr;
			old_ppsr = m_ppsr;
			if (wb_valid && !wb_dest_sys)
				m_greg[wb_dest] = wb_data;
			if (wb_valid && wb_dest_sys) begin
				case (wb_dest)
					5'd0: m_psr = wb_data;
					5'd1: m_spr = wb_data;
					5'd2: m_idtr = wb_data;
					5'd3: m_ppsr = wb_data;
					default: ;
				endcase
			end
			// Interrupt events override a writeback
			if (irq_enter) begin
				m_ppsr = old_psr;
				m_psr = old_psr & ~`ALLOC_PSR_IRQ_MASK;
			end else if (irq_return) begin
				m_psr = old_ppsr;
			end
		end
	end

	// Run limit is twice the total test length
	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles > 2 * N_TESTS * TEST_LEN) begin
			$display("timeout: the run did not finish within %0d cycles", cycles - 1);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Mode steers the random stimulus toward one behavior
	task automatic run_test(input int mode);
		int top;
		int start_errors;
		start_errors = errors;
		top = (mode == 1 || mode == 4) ? 3 : (mode == 2) ? 7 : 31;
		for (int cyc = 0; cyc < TEST_LEN; cyc++) begin
			@(posedge iCLOCK);
			#1;
			in_valid = (mode == 0) ? (cyc >= `ALLOC_NUM_GREGS) : ($urandom_range(0, 3) != 0);
			in_cmd = alloc_cmd_t'($urandom_range(0, 9));
			in_pc = $urandom;
			in_dest = greg_idx_t'($urandom);
			{in_dest_sys, in_writeback} = 2'($urandom);
			in_src0 = greg_idx_t'($urandom_range(0, top));
			in_src1 = greg_idx_t'($urandom_range(0, top));
			in_src0_sys = (mode != 0) && ($urandom_range(0, 1) != 0);
			in_src1_sys = (mode != 0) && ($urandom_range(0, 1) != 0);
			in_src1_imm = (mode >= 2) && ($urandom_range(0, 2) == 0);
			in_imm = $urandom;
			out_ready = (mode <= 1) || ($urandom_range(0, 2) != 0);
			wb_valid = (mode == 0) ? (cyc < `ALLOC_NUM_GREGS) :
				((mode == 1) || ($urandom_range(0, 1) != 0));
			wb_dest = (mode == 0) ? greg_idx_t'(cyc) : ($urandom_range(0, 1) != 0) ? in_src0 :
				greg_idx_t'($urandom_range(0, top));
			wb_dest_sys = (mode != 0) && ($urandom_range(0, 1) != 0);
			wb_data = $urandom;
			irq_enter = (mode == 4) && ($urandom_range(0, 3) == 0);
			irq_return = (mode == 4) && !irq_enter && ($urandom_range(0, 3) == 0);
			flush = (mode == 5) && !flush && ($urandom_range(0, 3) == 0);
		end
		$display("test %s: %0d errors", names[mode], errors - start_errors);
	endtask

	initial begin
		void'($urandom(76));
		inRESET = 1'b0;
		in_cmd = CMD_NOP;
		{in_valid, in_dest_sys, in_writeback, in_src0_sys, in_src1_sys, in_src1_imm} = '0;
		{in_pc, in_dest, in_src0, in_src1, in_imm, out_ready} = '0;
		{wb_valid, wb_dest, wb_dest_sys, wb_data, flush, irq_enter, irq_return} = '0;
		repeat (5) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		// Drain whatever is still held
		@(posedge iCLOCK);
		#1;
		{in_valid, wb_valid, flush, irq_enter, irq_return} = '0;
		out_ready = 1'b1;
		while (exp_q.size() != 0)
			@(posedge iCLOCK);
		@(negedge iCLOCK);
		#1;
		$display("tests: %0d, items checked: %0d, errors: %0d", N_TESTS, checked, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
alloc_reg_pkg.sv
alloc_op_pkg.sv
gen_reg_file.sv
sys_reg_bank.sv
operand_fetch.sv
alloc_pipe_reg.sv
alloc_stage.sv
tb_alloc_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_alloc_stage
FILELIST = src.f
SOURCES  = $(shell grep -v '^+' $(FILELIST)) alloc_defines.svh
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Succeeds only when the pass message shows up in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
